//--- common/isa_pkg.sv
package isa_pkg;

    typedef logic [15:0] inst_t;

    localparam int OPCODE_MSB = 15;
    localparam int OPCODE_LSB = 11;
    localparam int FUNC_MSB   = 1;
    localparam int FUNC_LSB   = 0;

    typedef enum logic [4:0] {
        op_halt    = 5'b00000,
        op_nop     = 5'b00001,
        op_illegal = 5'b00010,
        op_rti     = 5'b00011,
        op_j       = 5'b00100,
        op_jr      = 5'b00101,
        op_jal     = 5'b00110,
        op_jalr    = 5'b00111,
        op_addi    = 5'b01000,
        op_subi    = 5'b01001,
        op_xori    = 5'b01010,
        op_andni   = 5'b01011,
        op_beqz    = 5'b01100,
        op_bnez    = 5'b01101,
        op_bltz    = 5'b01110,
        op_bgez    = 5'b01111,
        op_st      = 5'b10000,
        op_ld      = 5'b10001,
        op_slbi    = 5'b10010,
        op_stu     = 5'b10011,
        op_roli    = 5'b10100,
        op_slli    = 5'b10101,
        op_rori    = 5'b10110,
        op_srli    = 5'b10111,
        op_lbi     = 5'b11000,
        op_btr     = 5'b11001,
        op_shift   = 5'b11010,  // Register rotates and shifts
        op_alu     = 5'b11011,  // Register add, sub, xor, andn
        op_seq     = 5'b11100,
        op_slt     = 5'b11101,
        op_sle     = 5'b11110,
        op_sco     = 5'b11111
    } opcode_e;

    // Function field of op_alu
    typedef enum logic [1:0] {
        func_add  = 2'b00,
        func_sub  = 2'b01,
        func_xor  = 2'b10,
        func_andn = 2'b11
    } alu_func_e;

    // Function field of op_shift
    typedef enum logic [1:0] {
        func_rol = 2'b00,
        func_sll = 2'b01,
        func_ror = 2'b10,
        func_srl = 2'b11
    } shift_func_e;

    function automatic opcode_e get_opcode(inst_t inst);
        return opcode_e'(inst[OPCODE_MSB:OPCODE_LSB]);
    endfunction

    function automatic logic [1:0] get_func(inst_t inst);
        return inst[FUNC_MSB:FUNC_LSB];
    endfunction

endpackage

//--- common/ctrl_pkg.sv
package ctrl_pkg;

    typedef enum logic [3:0] {
        alu_rol  = 4'd0,
        alu_sll  = 4'd1,
        alu_ror  = 4'd2,
        alu_srl  = 4'd3,
        alu_add  = 4'd4,
        alu_andn = 4'd5,
        alu_xor  = 4'd7,
        alu_slbi = 4'd8,   // Shift left then or in byte
        alu_sub  = 4'd9,
        alu_seq  = 4'd10,
        alu_slt  = 4'd11,
        alu_sle  = 4'd12,
        alu_sco  = 4'd13,  // Carry out of add
        alu_btr  = 4'd14,
        alu_lbi  = 4'd15
    } alu_op_e;

    typedef enum logic [1:0] {
        pc_hold   = 2'd0,
        pc_incr   = 2'd1,
        pc_target = 2'd2,  // Branch or jump address
        pc_epc    = 2'd3
    } pc_src_e;

    // Register file write index taken from the instruction
    typedef enum logic [1:0] {
        dst_rd_4_2  = 2'd0,
        dst_rt_7_5  = 2'd1,
        dst_rs_10_8 = 2'd2,
        dst_r7      = 2'd3
    } dst_sel_e;

    typedef enum logic [1:0] {
        ext_imm5   = 2'd0,
        ext_imm8   = 2'd1,
        ext_disp11 = 2'd2
    } ext_op_e;

    typedef enum logic [2:0] {
        br_beqz = 3'd0,
        br_bnez = 3'd1,
        br_bltz = 3'd2,
        br_bgez = 3'd3,
        br_j    = 3'd4,
        br_jr   = 3'd5,
        br_jal  = 3'd6,
        br_jalr = 3'd7
    } br_op_e;

    typedef struct packed {
        alu_op_e  alu_op;
        logic     alu_src;    // Immediate instead of rt
        logic     ext_sign;
        dst_sel_e dst_reg;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        logic     mem_reg;    // Write back memory data
    } exec_ctrl_t;

    typedef struct packed {
        pc_src_e pc_src;
        br_op_e  br_op;
        ext_op_e ext_op;
        logic    jal;         // Link the current PC
        logic    excp;
        logic    halt;
        logic    mem_en;
    } flow_ctrl_t;

    typedef struct packed {
        exec_ctrl_t exec;
        flow_ctrl_t flow;
    } ctrl_t;

endpackage

//--- decode/exec_decode.sv
`timescale 1ns/10ps

module exec_decode (
    input  isa_pkg::inst_t        inst,
    output ctrl_pkg::exec_ctrl_t  exec
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    opcode_e opcode;
    alu_op_e reg_alu_op;
    alu_op_e shift_alu_op;
    alu_op_e alu_sel;

    assign opcode = get_opcode(inst);

    always_comb begin
        case (alu_func_e'(get_func(inst)))
            func_add:  reg_alu_op = alu_add;
            func_sub:  reg_alu_op = alu_sub;
            func_xor:  reg_alu_op = alu_xor;
            func_andn: reg_alu_op = alu_andn;
            default:   reg_alu_op = alu_rol;
        endcase
    end

    always_comb begin
        case (shift_func_e'(get_func(inst)))
            func_rol: shift_alu_op = alu_rol;
            func_sll: shift_alu_op = alu_sll;
            func_ror: shift_alu_op = alu_ror;
            func_srl: shift_alu_op = alu_srl;
            default:  shift_alu_op = alu_rol;
        endcase
    end

    always_comb begin
        case (opcode)
            op_addi, op_st, op_ld, op_stu: alu_sel = alu_add;  // Address calc adds too
            op_subi:  alu_sel = alu_sub;
            op_xori:  alu_sel = alu_xor;
            op_andni: alu_sel = alu_andn;
            op_roli:  alu_sel = alu_rol;
            op_slli:  alu_sel = alu_sll;
            op_rori:  alu_sel = alu_ror;
            op_srli:  alu_sel = alu_srl;
            op_btr:   alu_sel = alu_btr;
            op_alu:   alu_sel = reg_alu_op;
            op_shift: alu_sel = shift_alu_op;
            op_seq:   alu_sel = alu_seq;
            op_slt:   alu_sel = alu_slt;
            op_sle:   alu_sel = alu_sle;
            op_sco:   alu_sel = alu_sco;
            op_lbi:   alu_sel = alu_lbi;
            op_slbi:  alu_sel = alu_slbi;
            default:  alu_sel = alu_rol;   // ALU unused
        endcase
    end

    always_comb begin
        exec.alu_op    = alu_sel;
        exec.alu_src   = 1'b0;
        exec.ext_sign  = 1'b0;
        exec.dst_reg   = dst_rd_4_2;
        exec.reg_write = 1'b0;
        exec.mem_read  = 1'b0;
        exec.mem_write = 1'b0;
        exec.mem_reg   = 1'b0;
        case (opcode)
            op_addi, op_subi: begin
                exec.alu_src   = 1'b1;
                exec.ext_sign  = 1'b1;
                exec.dst_reg   = dst_rt_7_5;
                exec.reg_write = 1'b1;
            end
            op_xori, op_andni, op_roli, op_slli, op_rori, op_srli: begin
                exec.alu_src   = 1'b1;
                exec.dst_reg   = dst_rt_7_5;
                exec.reg_write = 1'b1;
            end
            op_st: begin
                exec.alu_src   = 1'b1;
                exec.ext_sign  = 1'b1;
                exec.dst_reg   = dst_rt_7_5;
                exec.mem_write = 1'b1;
            end
            op_ld: begin
                exec.alu_src   = 1'b1;
                exec.ext_sign  = 1'b1;
                exec.dst_reg   = dst_rt_7_5;
                exec.reg_write = 1'b1;
                exec.mem_read  = 1'b1;
                exec.mem_reg   = 1'b1;
            end
            op_stu: begin
                exec.alu_src   = 1'b1;
                exec.ext_sign  = 1'b1;
                exec.dst_reg   = dst_rs_10_8;  // Base register gets the address
                exec.reg_write = 1'b1;
                exec.mem_write = 1'b1;
            end
            op_btr, op_alu, op_shift, op_seq, op_slt, op_sle, op_sco:
                exec.reg_write = 1'b1;
            op_lbi, op_slbi: begin
                exec.alu_src   = 1'b1;
                exec.ext_sign  = (opcode == op_lbi);
                exec.dst_reg   = dst_rs_10_8;
                exec.reg_write = 1'b1;
            end
            op_beqz, op_bnez, op_bltz, op_bgez, op_j, op_jr:
                exec.ext_sign = 1'b1;
            op_jal, op_jalr: begin
                exec.ext_sign  = 1'b1;
                exec.dst_reg   = dst_r7;
                exec.reg_write = 1'b1;
            end
            default: exec.reg_write = 1'b0;
        endcase
    end

endmodule

//--- decode/flow_decode.sv
`timescale 1ns/10ps

module flow_decode (
    input  isa_pkg::inst_t        inst,
    output ctrl_pkg::flow_ctrl_t  flow
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    opcode_e opcode;

    assign opcode = get_opcode(inst);

    always_comb begin
        flow.pc_src = pc_incr;
        flow.br_op  = br_beqz;
        flow.ext_op = ext_imm5;
        flow.jal    = 1'b0;
        flow.excp   = 1'b0;
        flow.halt   = 1'b0;
        flow.mem_en = 1'b1;
        case (opcode)
            op_halt: begin
                flow.pc_src = pc_hold;
                flow.halt   = 1'b1;
                flow.mem_en = 1'b0;  // Memory idle while halted
            end
            op_beqz, op_bnez, op_bltz, op_bgez: begin
                flow.pc_src = pc_target;
                flow.br_op  = br_op_e'({1'b0, opcode[1:0]});  // Low bits pick the test
                flow.ext_op = ext_imm8;
            end
            op_j: begin
                flow.pc_src = pc_target;
                flow.br_op  = br_j;
                flow.ext_op = ext_disp11;
            end
            op_jr: begin
                flow.pc_src = pc_target;
                flow.br_op  = br_jr;
                flow.ext_op = ext_imm8;
            end
            op_jal: begin
                flow.pc_src = pc_target;
                flow.br_op  = br_jal;
                flow.ext_op = ext_disp11;
                flow.jal    = 1'b1;
            end
            op_jalr: begin
                flow.pc_src = pc_target;
                flow.br_op  = br_jalr;
                flow.ext_op = ext_imm8;
                flow.jal    = 1'b1;
            end
            op_lbi, op_slbi: flow.ext_op = ext_imm8;
            op_illegal: begin
                flow.pc_src = pc_epc;
                flow.excp   = 1'b1;
            end
            op_rti: flow.pc_src = pc_epc;
            // Sequential rows keep the defaults
            op_nop, op_addi, op_subi, op_xori, op_andni,
            op_roli, op_slli, op_rori, op_srli,
            op_st, op_ld, op_stu, op_btr, op_alu, op_shift,
            op_seq, op_slt, op_sle, op_sco: ;
            default: flow.mem_en = 1'b0;
        endcase
    end

endmodule

//--- decode/ctrl_reg.sv
`timescale 1ns/10ps

module ctrl_reg (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  inst_valid,
    input  ctrl_pkg::exec_ctrl_t  exec,
    input  ctrl_pkg::flow_ctrl_t  flow,
    output logic                  ctrl_valid,
    output ctrl_pkg::ctrl_t       ctrl
);

    // Strobe follows the input every cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl_valid <= 1'b0;
        end else begin
            ctrl_valid <= inst_valid;
        end
    end

    // Control word holds its last value between valid instructions
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl <= '0;  // Clears halt, excp and write enables
        end else if (inst_valid) begin
            ctrl.exec <= exec;
            ctrl.flow <= flow;
        end
    end

endmodule

//--- src/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             inst_valid,
    input  isa_pkg::inst_t   inst,
    output logic             ctrl_valid,
    output ctrl_pkg::ctrl_t  ctrl
);
    import ctrl_pkg::*;

    exec_ctrl_t exec;  // Datapath half
    flow_ctrl_t flow;  // Program flow half

    exec_decode u_exec_decode (
        .inst (inst),
        .exec (exec)
    );

    flow_decode u_flow_decode (
        .inst (inst),
        .flow (flow)
    );

    ctrl_reg u_ctrl_reg (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .exec       (exec),
        .flow       (flow),
        .ctrl_valid (ctrl_valid),
        .ctrl       (ctrl)
    );

endmodule

//--- dv/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Expected control word for one instruction, built one field at a time
function automatic ctrl_t expected_ctrl(input inst_t i);
    ctrl_t      c;
    opcode_e    op;
    logic [1:0] fn;
    logic       branch;
    logic       imm_alu;
    op      = opcode_e'(i[OPCODE_MSB:OPCODE_LSB]);
    fn      = i[FUNC_MSB:FUNC_LSB];
    branch  = op inside {op_beqz, op_bnez, op_bltz, op_bgez};
    imm_alu = op inside {op_addi, op_subi, op_xori, op_andni,
                         op_roli, op_slli, op_rori, op_srli};
    c = '0;

    case (op)
        op_addi, op_st, op_ld, op_stu: c.exec.alu_op = alu_add;
        op_subi:  c.exec.alu_op = alu_sub;
        op_xori:  c.exec.alu_op = alu_xor;
        op_andni: c.exec.alu_op = alu_andn;
        op_roli:  c.exec.alu_op = alu_rol;
        op_slli:  c.exec.alu_op = alu_sll;
        op_rori:  c.exec.alu_op = alu_ror;
        op_srli:  c.exec.alu_op = alu_srl;
        op_alu:   c.exec.alu_op = (fn == 2'd0) ? alu_add : (fn == 2'd1) ? alu_sub :
                                  (fn == 2'd2) ? alu_xor : alu_andn;
        op_shift: c.exec.alu_op = (fn == 2'd0) ? alu_rol : (fn == 2'd1) ? alu_sll :
                                  (fn == 2'd2) ? alu_ror : alu_srl;
        op_seq:   c.exec.alu_op = alu_seq;
        op_slt:   c.exec.alu_op = alu_slt;
        op_sle:   c.exec.alu_op = alu_sle;
        op_sco:   c.exec.alu_op = alu_sco;
        op_btr:   c.exec.alu_op = alu_btr;
        op_lbi:   c.exec.alu_op = alu_lbi;
        op_slbi:  c.exec.alu_op = alu_slbi;
        default:  c.exec.alu_op = alu_rol;  // No ALU use
    endcase

    c.exec.alu_src   = imm_alu || op inside {op_st, op_ld, op_stu, op_lbi, op_slbi};
    c.exec.ext_sign  = branch || op inside {op_addi, op_subi, op_st, op_ld, op_stu, op_lbi,
                                            op_j, op_jr, op_jal, op_jalr};
    c.exec.reg_write = imm_alu || op inside {op_ld, op_stu, op_btr, op_alu, op_shift,
                                             op_seq, op_slt, op_sle, op_sco,
                                             op_lbi, op_slbi, op_jal, op_jalr};
    c.exec.mem_read  = (op == op_ld);
    c.exec.mem_write = op inside {op_st, op_stu};
    c.exec.mem_reg   = (op == op_ld);

    if (op inside {op_jal, op_jalr})
        c.exec.dst_reg = dst_r7;
    else if (op inside {op_stu, op_lbi, op_slbi})
        c.exec.dst_reg = dst_rs_10_8;
    else if (imm_alu || op inside {op_st, op_ld})
        c.exec.dst_reg = dst_rt_7_5;
    else
        c.exec.dst_reg = dst_rd_4_2;

    if (op == op_halt)
        c.flow.pc_src = pc_hold;
    else if (op inside {op_illegal, op_rti})
        c.flow.pc_src = pc_epc;
    else if (branch || op inside {op_j, op_jr, op_jal, op_jalr})
        c.flow.pc_src = pc_target;
    else
        c.flow.pc_src = pc_incr;

    case (op)
        op_bnez: c.flow.br_op = br_bnez;
        op_bltz: c.flow.br_op = br_bltz;
        op_bgez: c.flow.br_op = br_bgez;
        op_j:    c.flow.br_op = br_j;
        op_jr:   c.flow.br_op = br_jr;
        op_jal:  c.flow.br_op = br_jal;
        op_jalr: c.flow.br_op = br_jalr;
        default: c.flow.br_op = br_beqz;
    endcase

    if (branch || op inside {op_jr, op_jalr, op_lbi, op_slbi})
        c.flow.ext_op = ext_imm8;
    else if (op inside {op_j, op_jal})
        c.flow.ext_op = ext_disp11;
    else
        c.flow.ext_op = ext_imm5;

    c.flow.jal    = op inside {op_jal, op_jalr};
    c.flow.excp   = (op == op_illegal);
    c.flow.halt   = (op == op_halt);
    c.flow.mem_en = (op != op_halt);
    return c;
endfunction

`endif

//--- dv/tb_decode_stage.sv
`timescale 1ns/10ps

module tb_decode_stage;
    import isa_pkg::*;
    import ctrl_pkg::*;

    `include "decode_model.svh"

    localparam int RESET_CYCLES   = 4;
    localparam int STREAM_LEN     = 200;
    localparam int DIRECTED_TESTS = 42;  // Two cycles each
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 2 * DIRECTED_TESTS + STREAM_LEN + 100;

    logic        clk;
    logic        rst_n;
    logic        inst_valid;
    inst_t       inst;
    logic        ctrl_valid;
    ctrl_t       ctrl;
    int          errors;
    int unsigned lcg_state;
    ctrl_t       held_ctrl;  // Word the register should be holding

    decode_stage dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .ctrl_valid (ctrl_valid),
        .ctrl       (ctrl)
    );

    always #4 clk = ~clk;

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    // Random register fields around a fixed opcode and function
    function automatic inst_t make_inst(input opcode_e op, input logic [1:0] func);
        logic [15:0] r;
        r = lcg_next();
        return {op, r[10:2], func};
    endfunction

    task automatic check_field(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        assert (exp_val == act_val) else begin
            errors++;
            $display("ERR %s expected %h actual %h at %0t", name, exp_val, act_val, $time);
        end
    endtask

    task automatic check_outputs(input logic exp_valid, input ctrl_t exp);
        check_field("ctrl_valid", 32'(exp_valid), 32'(ctrl_valid));
        check_field("alu_op", 32'(exp.exec.alu_op), 32'(ctrl.exec.alu_op));
        check_field("alu_src", 32'(exp.exec.alu_src), 32'(ctrl.exec.alu_src));
        check_field("ext_sign", 32'(exp.exec.ext_sign), 32'(ctrl.exec.ext_sign));
        check_field("dst_reg", 32'(exp.exec.dst_reg), 32'(ctrl.exec.dst_reg));
        check_field("reg_write", 32'(exp.exec.reg_write), 32'(ctrl.exec.reg_write));
        check_field("mem_read", 32'(exp.exec.mem_read), 32'(ctrl.exec.mem_read));
        check_field("mem_write", 32'(exp.exec.mem_write), 32'(ctrl.exec.mem_write));
        check_field("mem_reg", 32'(exp.exec.mem_reg), 32'(ctrl.exec.mem_reg));
        check_field("pc_src", 32'(exp.flow.pc_src), 32'(ctrl.flow.pc_src));
        check_field("br_op", 32'(exp.flow.br_op), 32'(ctrl.flow.br_op));
        check_field("ext_op", 32'(exp.flow.ext_op), 32'(ctrl.flow.ext_op));
        check_field("jal", 32'(exp.flow.jal), 32'(ctrl.flow.jal));
        check_field("excp", 32'(exp.flow.excp), 32'(ctrl.flow.excp));
        check_field("halt", 32'(exp.flow.halt), 32'(ctrl.flow.halt));
        check_field("mem_en", 32'(exp.flow.mem_en), 32'(ctrl.flow.mem_en));
    endtask

    task automatic apply_inst(input inst_t value, input logic valid);
        ctrl_t exp;
        exp = valid ? expected_ctrl(value) : held_ctrl;
        @(posedge clk);
        inst       <= value;
        inst_valid <= valid;
        @(posedge clk);  // Sampled here, visible one cycle later
        @(negedge clk);
        check_outputs(valid, exp);
        held_ctrl = exp;
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_outputs(1'b0, held_ctrl);
        apply_inst(make_inst(op_jal, 2'b00), 1'b1);
        // Reset wins over a valid instruction on the same edge
        @(posedge clk);
        rst_n      <= 1'b0;
        inst       <= make_inst(op_halt, 2'b00);
        inst_valid <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        held_ctrl = '0;
        check_outputs(1'b0, held_ctrl);
        @(posedge clk);
        rst_n      <= 1'b1;
        inst_valid <= 1'b0;
        apply_inst(make_inst(op_jal, 2'b00), 1'b0);
    endtask

    task automatic test_alu_ops();
        opcode_e ops [13];
        ops = '{op_addi, op_subi, op_xori, op_andni, op_roli, op_slli, op_rori,
                op_srli, op_seq, op_slt, op_sle, op_sco, op_btr};
        foreach (ops[k])
            apply_inst(make_inst(ops[k], 2'b00), 1'b1);
        for (int f = 0; f < 4; f++) begin
            apply_inst(make_inst(op_alu, 2'(f)), 1'b1);
            apply_inst(make_inst(op_shift, 2'(f)), 1'b1);
        end
    endtask

    task automatic test_memory();
        opcode_e ops [5];
        ops = '{op_st, op_ld, op_stu, op_lbi, op_slbi};
        foreach (ops[k])
            apply_inst(make_inst(ops[k], 2'b10), 1'b1);
    endtask

    task automatic test_flow();
        opcode_e ops [8];
        ops = '{op_beqz, op_bnez, op_bltz, op_bgez, op_j, op_jr, op_jal, op_jalr};
        foreach (ops[k])
            apply_inst(make_inst(ops[k], 2'b01), 1'b1);
    endtask

    task automatic test_special();
        opcode_e ops [4];
        ops = '{op_halt, op_nop, op_illegal, op_rti};
        foreach (ops[k])
            apply_inst(make_inst(ops[k], 2'b11), 1'b1);
    endtask

    // One word per cycle, each checked at the next falling edge
    task automatic test_stream();
        logic [15:0] r;
        logic        v;
        inst_t       value;
        logic        valid_prev;
        ctrl_t       exp_prev;
        valid_prev = 1'b0;
        exp_prev   = held_ctrl;
        for (int n = 0; n < STREAM_LEN; n++) begin
            r     = lcg_next();
            value = lcg_next();
            v     = r[3] | r[9];
            @(posedge clk);
            inst       <= value;
            inst_valid <= v;
            @(negedge clk);
            if (n > 0)
                check_outputs(valid_prev, exp_prev);
            if (v)
                held_ctrl = expected_ctrl(value);
            valid_prev = v;
            exp_prev   = held_ctrl;
        end
        @(posedge clk);
        inst_valid <= 1'b0;
        @(negedge clk);
        check_outputs(valid_prev, exp_prev);
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        errors     = 0;
        lcg_state  = 81;
        held_ctrl  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_alu_ops();
        test_memory();
        test_flow();
        test_special();
        test_stream();
        $display("Decode stage checks complete, error count %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, the tests did not complete", TIMEOUT_CYCLES);
        $display("Finished with errors");
        $finish;
    end

endmodule

//--- tb.f
+incdir+dv
common/isa_pkg.sv
common/ctrl_pkg.sv
decode/exec_decode.sv
decode/flow_decode.sv
decode/ctrl_reg.sv
src/decode_stage.sv
dv/tb_decode_stage.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_decode_stage
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Finished with no errors

.PHONY: sim clean

# Pipeline status comes from grep, so a missing pass line fails the target
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
